/* Makefile */
TOP = tb_tile_transpose

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tile_transpose.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* logic/chunk_fifo.sv */
// Valid/ready circular FIFO
`timescale 1ns/10ps

module chunk_fifo #(
  parameter int DEPTH = 2,
  parameter type item_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst,

  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,

  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  item_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic full;
  logic empty;
  logic do_write;
  logic do_read;

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr];

  assign do_write = in_valid && !full;
  assign do_read  = out_ready && !empty;

  always_comb begin
    count_next = count;
    if (do_write && !do_read) begin
      count_next = count + 1'b1;
    end else if (do_read && !do_write) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // Flags registered from the next occupancy
      full  <= (count_next == CNT_W'(DEPTH));
      empty <= (count_next == '0);
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(DEPTH))
    else $error("chunk_fifo occupancy above DEPTH");

  // Head item holds while the reader stalls
  a_head_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> $stable(out_data))
    else $error("chunk_fifo head changed under back-pressure");

endmodule

/* logic/matrix_stream_transpose.sv */
// Streaming tiled matrix transpose
`timescale 1ns/10ps

module matrix_stream_transpose #(
  parameter int TOTAL_DIM0 = 4,
  parameter int TOTAL_DIM1 = 4
) (
  input  logic                      clk,
  input  logic                      rst,

  input  tile_geom_pkg::tile_t      in_tile,
  input  logic                      in_valid,
  output logic                      in_ready,

  output tile_stream_pkg::tile_out_t out_beat,
  output logic                      out_valid,
  input  logic                      out_ready
);

  import tile_geom_pkg::*;
  import tile_stream_pkg::*;

  initial begin
    assert (TOTAL_DIM0 % COMPUTE_DIM0 == 0)
    else $fatal(1, "TOTAL_DIM0 is not a multiple of the tile width");
    assert (TOTAL_DIM1 % COMPUTE_DIM1 == 0)
    else $fatal(1, "TOTAL_DIM1 is not a multiple of the tile height");
  end

  // Input grid in tiles, output grid is its transpose
  localparam int IN_COLS  = TOTAL_DIM0 / COMPUTE_DIM0;
  localparam int IN_ROWS  = TOTAL_DIM1 / COMPUTE_DIM1;
  localparam int OUT_ROWS = IN_COLS;
  localparam int OUT_COLS = IN_ROWS;

  localparam int IN_COL_W  = (IN_COLS > 1) ? $clog2(IN_COLS) : 1;
  localparam int OUT_ROW_W = (OUT_ROWS > 1) ? $clog2(OUT_ROWS) : 1;
  localparam int OUT_COL_W = (OUT_COLS > 1) ? $clog2(OUT_COLS) : 1;

  // Tile position on each side of the transposer
  typedef struct packed {
    logic [IN_COL_W-1:0]  in_col_count;
    logic [OUT_ROW_W-1:0] out_row_count;
    logic [OUT_COL_W-1:0] out_col_count;
  } state_t;

  state_t state;
  state_t state_next;

  logic [IN_COLS-1:0] fifo_wr_valid;
  logic [IN_COLS-1:0] fifo_wr_ready;
  logic [IN_COLS-1:0] fifo_rd_valid;
  logic [IN_COLS-1:0] fifo_rd_ready;
  tile_t              fifo_rd_data [IN_COLS];

  tile_t head_tile;
  tile_t head_transposed;
  logic  row_end;
  logic  matrix_end;

  // One FIFO per input tile column
  for (genvar i = 0; i < IN_COLS; i++) begin : g_bank
    assign fifo_wr_valid[i] = (state.in_col_count == IN_COL_W'(i)) && in_valid;
    assign fifo_rd_ready[i] = (state.out_row_count == OUT_ROW_W'(i)) && out_ready;

    chunk_fifo #(
      .DEPTH  (IN_ROWS),
      .item_t (tile_t)
    ) fifo_i (
      .clk       (clk),
      .rst       (rst),
      .in_data   (in_tile),
      .in_valid  (fifo_wr_valid[i]),
      .in_ready  (fifo_wr_ready[i]),
      .out_data  (fifo_rd_data[i]),
      .out_valid (fifo_rd_valid[i]),
      .out_ready (fifo_rd_ready[i])
    );
  end

  assign in_ready  = fifo_wr_ready[state.in_col_count];
  assign out_valid = fifo_rd_valid[state.out_row_count];
  assign head_tile = fifo_rd_data[state.out_row_count];

  // Swap rows and columns inside the tile
  always_comb begin
    head_transposed = '0;
    for (int r = 0; r < COMPUTE_DIM1; r++) begin
      for (int c = 0; c < COMPUTE_DIM0; c++) begin
        head_transposed[c * COMPUTE_DIM1 + r] = head_tile[r * COMPUTE_DIM0 + c];
      end
    end
  end

  assign row_end    = (state.out_col_count == OUT_COL_W'(OUT_COLS - 1));
  assign matrix_end = row_end && (state.out_row_count == OUT_ROW_W'(OUT_ROWS - 1));
  assign out_beat   = make_beat(head_transposed, row_end, matrix_end);

  always_comb begin
    state_next = state;

    // Input column wraps at the end of each tile row
    if (in_valid && in_ready) begin
      if (state.in_col_count == IN_COL_W'(IN_COLS - 1)) begin
        state_next.in_col_count = '0;
      end else begin
        state_next.in_col_count = state.in_col_count + 1'b1;
      end
    end

    // Output drains one FIFO per output tile row
    if (out_valid && out_ready) begin
      if (row_end) begin
        state_next.out_col_count = '0;
        if (matrix_end) begin
          state_next.out_row_count = '0;
        end else begin
          state_next.out_row_count = state.out_row_count + 1'b1;
        end
      end else begin
        state_next.out_col_count = state.out_col_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
    end else begin
      state <= state_next;
    end
  end

  // An accepted tile lands in exactly the FIFO of its column
  a_write_steer: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) |->
      ((fifo_wr_valid & fifo_wr_ready) == (IN_COLS'(1) << state.in_col_count)))
    else $error("input tile accepted while selected FIFO is full");

endmodule

/* logic/tile_geom_pkg.sv */
// Compute tile geometry
package tile_geom_pkg;

  // Element width in bits
  localparam int ELEM_WIDTH = 8;

  // Compute tile shape, columns by rows
  localparam int COMPUTE_DIM0 = 2;
  localparam int COMPUTE_DIM1 = 2;

  // Elements carried by one tile
  localparam int TILE_ELEMS = COMPUTE_DIM0 * COMPUTE_DIM1;

  // One matrix element
  typedef logic [ELEM_WIDTH-1:0] elem_t;

  // Row-major tile, element index is row * COMPUTE_DIM0 + col
  // Element 0 sits in the lowest bits
  typedef elem_t [TILE_ELEMS-1:0] tile_t;

endpackage

/* logic/tile_stream_pkg.sv */
// Output stream beat types
package tile_stream_pkg;

  // One beat of the transposed output stream
  typedef struct packed {
    tile_geom_pkg::tile_t tile;
    // Last tile of an output tile row
    logic row_end;
    // Last tile of the matrix
    logic matrix_end;
  } tile_out_t;

  // Assemble an output beat from a tile and its position flags
  function automatic tile_out_t make_beat(
    input tile_geom_pkg::tile_t tile,
    input logic row_end,
    input logic matrix_end
  );
    tile_out_t beat;
    beat.tile = tile;
    beat.row_end = row_end;
    beat.matrix_end = matrix_end;
    return beat;
  endfunction

endpackage

/* logic/tile_transpose_top.sv */
// Tile transpose top level
`timescale 1ns/10ps

module tile_transpose_top (
  input  logic                       clk,
  input  logic                       rst,

  input  tile_geom_pkg::tile_t       in_tile,
  input  logic                       in_valid,
  output logic                       in_ready,

  output tile_stream_pkg::tile_out_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);

  // 6 x 4 matrix, 3 FIFOs each 2 tiles deep
  localparam int MATRIX_DIM0 = 6;
  localparam int MATRIX_DIM1 = 4;

  matrix_stream_transpose #(
    .TOTAL_DIM0 (MATRIX_DIM0),
    .TOTAL_DIM1 (MATRIX_DIM1)
  ) transpose_i (
    .clk       (clk),
    .rst       (rst),
    .in_tile   (in_tile),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* test/tb_tile_transpose.sv */
// Tile transpose testbench
`timescale 1ns/10ps

module tb_tile_transpose;

  import tile_geom_pkg::*;
  import tile_stream_pkg::*;

  localparam int TILES          = 6;
  localparam int RECORD_WORDS   = 2 + 2 * TILES;
  localparam int NUM_RECORDS    = 7;
  localparam int NUM_WORDS      = NUM_RECORDS * RECORD_WORDS;
  localparam int TIMEOUT_CYCLES = 40 * NUM_RECORDS * TILES;

  // Stall modes as coded in the golden file
  localparam int MODE_PLAIN     = 0;
  localparam int MODE_OUT_STALL = 1;
  localparam int MODE_IN_GAP    = 2;
  localparam int MODE_CAPACITY  = 3;

  localparam logic [31:0] SEED = 32'he357_9585;

  logic      clk;
  logic      rst;
  tile_t     in_tile;
  logic      in_valid;
  logic      in_ready;
  tile_out_t out_beat;
  logic      out_valid;
  logic      out_ready;

  // Per record: id, mode, input tiles, expected beats
  logic [33:0] golden [NUM_WORDS];
  int          records_done;
  logic        capacity_done;
  int          cycle_count = 0;
  logic [31:0] drv_rand;
  logic [31:0] mon_rand;

  tile_transpose_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_tile   (in_tile),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string mode_name(input int mode);
    case (mode)
      MODE_PLAIN:     return "plain";
      MODE_OUT_STALL: return "out_stall";
      MODE_IN_GAP:    return "in_gap";
      MODE_CAPACITY:  return "capacity";
      default:        return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [33:0] expected,
                             input logic [33:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic drive_record(input int rec);
    int    base;
    int    mode;
    int    gap;
    logic  fire;
    string name;
    base = rec * RECORD_WORDS;
    mode = int'(golden[base + 1]);
    name = $sformatf("%s_%0d", mode_name(mode), golden[base]);
    check_value({name, " record id"}, 34'(rec + 1), golden[base]);
    // Capacity run starts from an empty FIFO bank
    if (mode == MODE_CAPACITY) begin
      wait (records_done == rec);
      @(posedge clk);
      #1;
    end
    for (int k = 0; k < TILES; k++) begin
      if (mode == MODE_IN_GAP) begin
        drv_rand = next_random(drv_rand);
        gap = int'(drv_rand[1:0]);
        in_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      in_tile  = golden[base + 2 + k][31:0];
      in_valid = 1'b1;
      fire = 1'b0;
      while (!fire) begin
        @(negedge clk);
        if (mode == MODE_CAPACITY) begin
          check_value({name, " ready before full"}, 34'd1, {33'd0, in_ready});
        end
        fire = in_ready;
        @(posedge clk);
        #1;
      end
    end
    in_valid = 1'b0;
    if (mode == MODE_CAPACITY) begin
      // Every FIFO holds two tiles now
      repeat (4) begin
        @(negedge clk);
        check_value({name, " ready when full"}, 34'd0, {33'd0, in_ready});
      end
      capacity_done = 1'b1;
    end
  endtask

  task automatic check_record(input int rec);
    int        base;
    int        mode;
    int        n;
    logic      stalled;
    tile_out_t held;
    string     name;
    base    = rec * RECORD_WORDS;
    mode    = int'(golden[base + 1]);
    n       = 0;
    stalled = 1'b0;
    held    = '0;
    out_ready = (mode == MODE_CAPACITY) ? 1'b0 : 1'b1;
    while (n < TILES) begin
      @(negedge clk);
      name = $sformatf("%s_%0d beat %0d", mode_name(mode), golden[base], n);
      // Beat must hold under back-pressure
      if (stalled) begin
        check_value({name, " hold valid"}, 34'd1, {33'd0, out_valid});
        check_value({name, " hold data"}, held, out_beat);
      end
      if (out_valid && out_ready) begin
        check_value(name, golden[base + 2 + TILES + n], out_beat);
        n++;
      end
      stalled = out_valid && !out_ready;
      held    = out_beat;
      @(posedge clk);
      #1;
      if (mode == MODE_OUT_STALL) begin
        mon_rand  = next_random(mon_rand);
        out_ready = mon_rand[0];
      end else if (mode == MODE_CAPACITY) begin
        out_ready = capacity_done;
      end else begin
        out_ready = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles with %0d of %0d records checked",
               cycle_count, records_done, NUM_RECORDS);
      $display("TB FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    rst           = 1'b1;
    in_tile       = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b0;
    capacity_done = 1'b0;
    records_done  = 0;
    drv_rand      = SEED;
    mon_rand      = next_random(SEED);
    $readmemh("test/tile_transpose_golden.mem", golden);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      begin
        for (int rec = 0; rec < NUM_RECORDS; rec++) begin
          drive_record(rec);
        end
      end
      begin
        for (int rec = 0; rec < NUM_RECORDS; rec++) begin
          check_record(rec);
          records_done++;
        end
      end
    join
    $display("TB PASSED");
    $finish;
  end

endmodule

/* test/tile_transpose_golden.mem */
// Record line: test id, stall mode (0 plain, 1 out stall, 2 in gap, 3 capacity), 6 input tiles
// Next line: 6 expected beats as {tile, row_end, matrix_end}
// Single matrix without stalls
001 000 27262120 29282322 2b2a2524 33322d2c 35342f2e 37363130
09c849880 0ccb4c8b2 0a48ca088 0d4bcd0ba 0ac94a890 0dcc4d8c3
// Back to back matrix one
002 000 47464140 49484342 4b4a4544 53524d4c 55544f4e 57565150
11d051900 14d354932 1250d2108 1553d513a 12d152910 15d455943
// Back to back matrix two
003 000 67666160 69686362 6b6a6564 73726d6c 75746f6e 77767170
19d859980 1cdb5c9b2 1a58da188 1d5bdd1ba 1ad95a990 1ddc5d9c3
// Back to back matrix three
004 000 87868180 89888382 8b8a8584 93928d8c 95948f8e 97969190
21e061a00 24e364a32 2260e2208 2563e523a 22e162a10 25e465a43
// Random output stalls
005 001 a7a6a1a0 a9a8a3a2 abaaa5a4 b3b2adac b5b4afae b7b6b1b0
29e869a80 2ceb6cab2 2a68ea288 2d6bed2ba 2ae96aa90 2dec6dac3
// Random input gaps
006 002 c7c6c1c0 c9c8c3c2 cbcac5c4 d3d2cdcc d5d4cfce d7d6d1d0
31f071b00 34f374b32 3270f2308 3573f533a 32f172b10 35f475b43
// Capacity with output held off
007 003 e7e6e1e0 e9e8e3e2 ebeae5e4 f3f2edec f5f4efee f7f6f1f0
39f879b80 3cfb7cbb2 3a78fa388 3d7bfd3ba 3af97ab90 3dfc7dbc3

/* tile_transpose.f */
logic/tile_geom_pkg.sv
logic/tile_stream_pkg.sv
logic/chunk_fifo.sv
logic/matrix_stream_transpose.sv
logic/tile_transpose_top.sv
test/tb_tile_transpose.sv
